// ==== all.f ====
+incdir+rtl
rtl/rv_pkg.sv
rtl/pipe_reg.sv
rtl/reg_file.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/hazard_unit.sv
rtl/rv_pipeline.sv
verification/rv_pipeline_props.sv
verification/rv_pipeline_tb.sv

// ==== rtl/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module decode_unit import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  id_payload_t            id_in,
    input  logic                   wb_write_enable,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data,
    input  logic [`XLEN-1:0]       mem_result,
    input  logic [`XLEN-1:0]       wb_result,
    input  fwd_sel_t               rs1_fwd,
    input  fwd_sel_t               rs2_fwd,
    output ex_payload_t            ex_out,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic                   uses_rs1,
    output logic                   uses_rs2,
    output logic                   is_branch,
    output logic                   redirect,
    output logic [`XLEN-1:0]       target_pc
);

    logic [`XLEN-1:0] instr;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [`XLEN-1:0] rf_rs1, rf_rs2, rs1_val, rs2_val;
    logic             is_jal, taken;

    // anything outside the subset is replaced by a NOP
    always_comb begin
        case (id_in.instr[6:0])
            `OP_RTYPE, `OP_ITYPE, `OP_LUI, `OP_LOAD,
            `OP_STORE, `OP_BRANCH, `OP_JAL: instr = id_in.instr;
            default:                        instr = `INST_NOP;
        endcase
    end

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    reg_file rf_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rf_rs1),
        .rs2_data     (rf_rs2),
        .write_enable (wb_write_enable),
        .write_addr   (wb_rd),
        .write_data   (wb_data)
    );

    assign rs1_val = fwd_mux(rs1_fwd, rf_rs1, mem_result, wb_result);
    assign rs2_val = fwd_mux(rs2_fwd, rf_rs2, mem_result, wb_result);

    always_comb begin
        ex_out             = '0;
        uses_rs1           = 1'b0;
        uses_rs2           = 1'b0;
        is_branch          = 1'b0;
        is_jal             = 1'b0;
        ex_out.pc_plus4    = id_in.pc + 32'd4;
        ex_out.rd          = instr[11:7];
        case (opcode)
            `OP_RTYPE: begin
                uses_rs1         = 1'b1;
                uses_rs2         = 1'b1;
                ex_out.reg_write = 1'b1;
                case (funct3)
                    `F3_ADD_SUB: ex_out.alu_op = (funct7 == `F7_SUB) ? ALU_SUB : ALU_ADD;
                    `F3_SLT:     ex_out.alu_op = ALU_SLT;
                    `F3_XOR:     ex_out.alu_op = ALU_XOR;
                    `F3_OR:      ex_out.alu_op = ALU_OR;
                    `F3_AND:     ex_out.alu_op = ALU_AND;
                    default:     ex_out.alu_op = ALU_ADD;
                endcase
            end
            `OP_ITYPE: begin
                uses_rs1           = 1'b1;
                ex_out.imm         = imm_i;
                ex_out.alu_src_imm = 1'b1;
                ex_out.reg_write   = 1'b1;
            end
            `OP_LUI: begin
                ex_out.imm         = imm_u;
                ex_out.alu_src_imm = 1'b1;
                ex_out.alu_op      = ALU_PASS_B;
                ex_out.reg_write   = 1'b1;
            end
            `OP_LOAD: begin
                uses_rs1           = 1'b1;
                ex_out.imm         = imm_i;
                ex_out.alu_src_imm = 1'b1;
                ex_out.mem_read    = 1'b1;
                ex_out.reg_write   = 1'b1;
                ex_out.wb_src      = WB_MEM;
            end
            `OP_STORE: begin
                uses_rs1           = 1'b1;
                uses_rs2           = 1'b1;
                ex_out.imm         = imm_s;
                ex_out.alu_src_imm = 1'b1;
                ex_out.mem_write   = 1'b1;
            end
            `OP_BRANCH: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                is_branch = 1'b1;
                ex_out.imm = imm_b;
            end
            `OP_JAL: begin
                is_jal           = 1'b1;
                ex_out.imm       = imm_j;
                ex_out.reg_write = 1'b1;
                ex_out.wb_src    = WB_PC4;
            end
            default: ;
        endcase
        // x0 destinations never write and never forward
        ex_out.reg_write = ex_out.reg_write && (ex_out.rd != '0);
        ex_out.rs1_addr  = uses_rs1 ? rs1_addr : '0;
        ex_out.rs2_addr  = uses_rs2 ? rs2_addr : '0;
        ex_out.rs1_data  = rs1_val;
        ex_out.rs2_data  = rs2_val;
    end

    assign taken     = (funct3 == `F3_BNE) ? (rs1_val != rs2_val) : (rs1_val == rs2_val);
    assign redirect  = is_jal || (is_branch && taken);
    assign target_pc = id_in.pc + ex_out.imm;

endmodule

`default_nettype wire

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module execute_unit import rv_pkg::*; (
    input  ex_payload_t      ex_in,
    input  logic [`XLEN-1:0] mem_result,
    input  logic [`XLEN-1:0] wb_result,
    input  fwd_sel_t         rs1_fwd,
    input  fwd_sel_t         rs2_fwd,
    output mem_payload_t     mem_out
);

    logic [`XLEN-1:0] op_a, rs2_val, op_b, alu_y;

    assign op_a    = fwd_mux(rs1_fwd, ex_in.rs1_data, mem_result, wb_result);
    assign rs2_val = fwd_mux(rs2_fwd, ex_in.rs2_data, mem_result, wb_result);
    assign op_b    = ex_in.alu_src_imm ? ex_in.imm : rs2_val;

    always_comb begin
        case (ex_in.alu_op)
            ALU_SUB:    alu_y = op_a - op_b;
            ALU_AND:    alu_y = op_a & op_b;
            ALU_OR:     alu_y = op_a | op_b;
            ALU_XOR:    alu_y = op_a ^ op_b;
            ALU_SLT:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_y = op_b;
            default:    alu_y = op_a + op_b;
        endcase
    end

    // store data is the bypassed rs2, not operand B
    assign mem_out.alu_result = alu_y;
    assign mem_out.store_data = rs2_val;
    assign mem_out.pc_plus4   = ex_in.pc_plus4;
    assign mem_out.mem_read   = ex_in.mem_read;
    assign mem_out.mem_write  = ex_in.mem_write;
    assign mem_out.reg_write  = ex_in.reg_write;
    assign mem_out.wb_src     = ex_in.wb_src;
    assign mem_out.rd         = ex_in.rd;

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module hazard_unit import rv_pkg::*; (
    input  logic [`REG_ADDR_W-1:0] rs1_addr_id,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_id,
    input  logic                   uses_rs1,
    input  logic                   uses_rs2,
    input  logic                   is_branch,
    input  logic                   redirect,
    input  ex_payload_t            ex_q,
    input  mem_payload_t           mem_q,
    input  wb_payload_t            wb_q,
    input  logic                   data_request_finish,
    output fwd_sel_t               id_rs1_fwd,
    output fwd_sel_t               id_rs2_fwd,
    output fwd_sel_t               ex_rs1_fwd,
    output fwd_sel_t               ex_rs2_fwd,
    output logic                   stall_if,
    output logic                   stall_id,
    output logic                   stall_ex,
    output logic                   stall_mem,
    output logic                   stall_wb,
    output logic                   bubble_id,
    output logic                   bubble_ex,
    output logic                   bubble_wb
);

    logic id_needs_ex, id_needs_mem;
    logic load_use, branch_ex, branch_mem_load, id_hold, bus_wait;

    // MEM wins over WB; a load's data is not ready in MEM
    function automatic fwd_sel_t fwd_source(
        input logic [`REG_ADDR_W-1:0] rs,
        input mem_payload_t           m,
        input wb_payload_t            w
    );
        fwd_sel_t sel;
        sel = FWD_REG;
        if (rs != '0 && m.reg_write && !m.mem_read && m.rd == rs) begin
            sel = FWD_MEM;
        end else if (rs != '0 && w.reg_write && w.rd == rs) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign id_rs1_fwd = fwd_source(uses_rs1 ? rs1_addr_id : '0, mem_q, wb_q);
    assign id_rs2_fwd = fwd_source(uses_rs2 ? rs2_addr_id : '0, mem_q, wb_q);
    assign ex_rs1_fwd = fwd_source(ex_q.rs1_addr, mem_q, wb_q);
    assign ex_rs2_fwd = fwd_source(ex_q.rs2_addr, mem_q, wb_q);

    // reg_write is never set for rd == x0
    assign id_needs_ex  = ex_q.reg_write &&
                          ((uses_rs1 && rs1_addr_id == ex_q.rd) ||
                           (uses_rs2 && rs2_addr_id == ex_q.rd));
    assign id_needs_mem = mem_q.reg_write &&
                          ((uses_rs1 && rs1_addr_id == mem_q.rd) ||
                           (uses_rs2 && rs2_addr_id == mem_q.rd));

    assign load_use        = ex_q.mem_read && id_needs_ex;
    assign branch_ex       = is_branch && id_needs_ex;
    assign branch_mem_load = is_branch && mem_q.mem_read && id_needs_mem;
    assign id_hold         = load_use || branch_ex || branch_mem_load;

    // MEM payload flags are the bus request levels
    assign bus_wait = (mem_q.mem_read || mem_q.mem_write) && !data_request_finish;

    always_comb begin
        stall_if  = 1'b0;
        stall_id  = 1'b0;
        stall_ex  = 1'b0;
        stall_mem = 1'b0;
        stall_wb  = 1'b0;
        bubble_id = 1'b0;
        bubble_ex = 1'b0;
        if (bus_wait) begin
            // whole pipe freezes until finish
            stall_if  = 1'b1;
            stall_id  = 1'b1;
            stall_ex  = 1'b1;
            stall_mem = 1'b1;
            stall_wb  = 1'b1;
        end else if (id_hold) begin
            stall_if  = 1'b1;
            stall_id  = 1'b1;
            bubble_ex = 1'b1;
        end else if (redirect) begin
            // drop the wrong-path fetch
            bubble_id = 1'b1;
        end
    end

    // WB only drains if MEM holds while WB moves on
    assign bubble_wb = stall_mem && !stall_wb;

endmodule

`default_nettype wire

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // an all-zero payload carries no write or request flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= payload_t'('0);
        end else if (bubble) begin
            q <= payload_t'('0);
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    input  logic                   write_enable,
    input  logic [`REG_ADDR_W-1:0] write_addr,
    input  logic [`XLEN-1:0]       write_data
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];
    logic             wr_live;

    assign wr_live = write_enable && (write_addr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[write_addr] <= write_data;
        end
    end

    // same-cycle write is seen by the ID read
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wr_live && write_addr == rs1_addr) ? write_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wr_live && write_addr == rs2_addr) ? write_data : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== rtl/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath and register file geometry
`define XLEN        32
`define REG_ADDR_W  5
`define REG_COUNT   32

`define RESET_PC    32'h0000_0000
// addi x0, x0, 0
`define INST_NOP    32'h0000_0013

// major opcodes
`define OP_RTYPE    7'b0110011
`define OP_ITYPE    7'b0010011
`define OP_LUI      7'b0110111
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111

// funct3 codes
`define F3_ADD_SUB  3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_LW       3'b010
`define F3_SW       3'b010
`define F3_BEQ      3'b000
`define F3_BNE      3'b001

// funct7 codes
`define F7_BASE     7'b0000000
`define F7_SUB      7'b0100000

`endif

// ==== rtl/rv_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_pipeline import rv_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    output logic [`XLEN-1:0] instr_addr,
    input  logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] data_addr,
    output logic [`XLEN-1:0] data_write_data,
    output logic             data_read_request,
    output logic             data_write_request,
    input  logic [`XLEN-1:0] data_read_data,
    input  logic             data_request_finish
);

    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       target_pc;
    logic                   redirect;
    logic [`XLEN-1:0]       mem_result;
    logic [`REG_ADDR_W-1:0] rs1_addr_id, rs2_addr_id;
    logic                   uses_rs1, uses_rs2, is_branch;
    logic                   stall_if, stall_id, stall_ex, stall_mem, stall_wb;
    logic                   bubble_id, bubble_ex, bubble_wb;
    fwd_sel_t               id_rs1_fwd, id_rs2_fwd, ex_rs1_fwd, ex_rs2_fwd;

    id_payload_t  id_d,  id_q;
    ex_payload_t  ex_d,  ex_q;
    mem_payload_t mem_d, mem_q;
    wb_payload_t  wb_d,  wb_q;

    // fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (!stall_if) begin
            pc <= redirect ? target_pc : pc + 32'd4;
        end
    end

    assign instr_addr = pc;
    assign id_d.pc    = pc;
    assign id_d.instr = instr;

    pipe_reg #(.payload_t(id_payload_t)) id_reg_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall_id),
        .bubble (bubble_id),
        .d      (id_d),
        .q      (id_q)
    );

    decode_unit dec_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .id_in           (id_q),
        .wb_write_enable (wb_q.reg_write),
        .wb_rd           (wb_q.rd),
        .wb_data         (wb_q.result),
        .mem_result      (mem_result),
        .wb_result       (wb_q.result),
        .rs1_fwd         (id_rs1_fwd),
        .rs2_fwd         (id_rs2_fwd),
        .ex_out          (ex_d),
        .rs1_addr        (rs1_addr_id),
        .rs2_addr        (rs2_addr_id),
        .uses_rs1        (uses_rs1),
        .uses_rs2        (uses_rs2),
        .is_branch       (is_branch),
        .redirect        (redirect),
        .target_pc       (target_pc)
    );

    pipe_reg #(.payload_t(ex_payload_t)) ex_reg_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall_ex),
        .bubble (bubble_ex),
        .d      (ex_d),
        .q      (ex_q)
    );

    execute_unit exe_i (
        .ex_in      (ex_q),
        .mem_result (mem_result),
        .wb_result  (wb_q.result),
        .rs1_fwd    (ex_rs1_fwd),
        .rs2_fwd    (ex_rs2_fwd),
        .mem_out    (mem_d)
    );

    // MEM is never bubbled, only frozen by the bus
    pipe_reg #(.payload_t(mem_payload_t)) mem_reg_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall_mem),
        .bubble (1'b0),
        .d      (mem_d),
        .q      (mem_q)
    );

    // bus is driven straight from the MEM payload
    assign data_addr          = mem_q.alu_result;
    assign data_write_data    = mem_q.store_data;
    assign data_read_request  = mem_q.mem_read;
    assign data_write_request = mem_q.mem_write;

    // load data is never bypassed out of MEM
    assign mem_result = (mem_q.wb_src == WB_PC4) ? mem_q.pc_plus4 : mem_q.alu_result;

    // write-back select, load data sampled on the finish edge
    assign wb_d.result    = (mem_q.wb_src == WB_MEM) ? data_read_data : mem_result;
    assign wb_d.reg_write = mem_q.reg_write;
    assign wb_d.rd        = mem_q.rd;

    pipe_reg #(.payload_t(wb_payload_t)) wb_reg_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall_wb),
        .bubble (bubble_wb),
        .d      (wb_d),
        .q      (wb_q)
    );

    hazard_unit haz_i (
        .rs1_addr_id         (rs1_addr_id),
        .rs2_addr_id         (rs2_addr_id),
        .uses_rs1            (uses_rs1),
        .uses_rs2            (uses_rs2),
        .is_branch           (is_branch),
        .redirect            (redirect),
        .ex_q                (ex_q),
        .mem_q               (mem_q),
        .wb_q                (wb_q),
        .data_request_finish (data_request_finish),
        .id_rs1_fwd          (id_rs1_fwd),
        .id_rs2_fwd          (id_rs2_fwd),
        .ex_rs1_fwd          (ex_rs1_fwd),
        .ex_rs2_fwd          (ex_rs2_fwd),
        .stall_if            (stall_if),
        .stall_id            (stall_id),
        .stall_ex            (stall_ex),
        .stall_mem           (stall_mem),
        .stall_wb            (stall_wb),
        .bubble_id           (bubble_id),
        .bubble_ex           (bubble_ex),
        .bubble_wb           (bubble_wb)
    );

endmodule

`default_nettype wire

// ==== rtl/rv_pkg.sv ====
`default_nettype none
`include "rv_defs.svh"

package rv_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_src_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    // IF -> ID
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } id_payload_t;

    // ID -> EX
    typedef struct packed {
        logic [`XLEN-1:0]       pc_plus4;
        logic [`REG_ADDR_W-1:0] rs1_addr;
        logic [`REG_ADDR_W-1:0] rs2_addr;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        alu_op_t                alu_op;
        logic                   alu_src_imm;
        logic                   mem_read;
        logic                   mem_write;
        logic                   reg_write;
        wb_src_t                wb_src;
        logic [`REG_ADDR_W-1:0] rd;
    } ex_payload_t;

    // EX -> MEM
    typedef struct packed {
        logic [`XLEN-1:0]       alu_result;
        logic [`XLEN-1:0]       store_data;
        logic [`XLEN-1:0]       pc_plus4;
        logic                   mem_read;
        logic                   mem_write;
        logic                   reg_write;
        wb_src_t                wb_src;
        logic [`REG_ADDR_W-1:0] rd;
    } mem_payload_t;

    // MEM -> WB, result already selected
    typedef struct packed {
        logic [`XLEN-1:0]       result;
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
    } wb_payload_t;

    // operand select shared by the ID and EX bypass paths
    function automatic logic [`XLEN-1:0] fwd_mux(
        input fwd_sel_t         sel,
        input logic [`XLEN-1:0] reg_val,
        input logic [`XLEN-1:0] mem_val,
        input logic [`XLEN-1:0] wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the rv_pipeline testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module rv_pipeline_tb -f all.f -o rv_pipeline_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rv_pipeline_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// ==== verification/rv_pipeline_props.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_pipeline_props (
    input logic             clk,
    input logic             rst_n,
    input logic [`XLEN-1:0] instr_addr,
    input logic [`XLEN-1:0] data_addr,
    input logic [`XLEN-1:0] data_write_data,
    input logic             data_read_request,
    input logic             data_write_request,
    input logic             data_request_finish
);

    logic read_fail  = 1'b0;
    logic write_fail = 1'b0;
    logic both_fail  = 1'b0;
    logic reset_fail = 1'b0;
    logic align_fail = 1'b0;
    logic any_failure;

    assign any_failure = read_fail | write_fail | both_fail | reset_fail | align_fail;

    // read level and address held until finish
    read_held: assert property (@(posedge clk) disable iff (!rst_n)
        (data_read_request && !data_request_finish) |=>
            (data_read_request && $stable(data_addr)))
        else begin
            read_fail = 1'b1;
            $error("read request changed before finish");
        end

    // a write also holds its data
    write_held: assert property (@(posedge clk) disable iff (!rst_n)
        (data_write_request && !data_request_finish) |=>
            (data_write_request && $stable(data_addr) && $stable(data_write_data)))
        else begin
            write_fail = 1'b1;
            $error("write request changed before finish");
        end

    one_request: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_read_request && data_write_request))
        else begin
            both_fail = 1'b1;
            $error("read and write requests high together");
        end

    // first edge out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!data_read_request && !data_write_request))
        else begin
            reset_fail = 1'b1;
            $error("bus request high in the cycle after reset");
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        instr_addr[1:0] == 2'b00)
        else begin
            align_fail = 1'b1;
            $error("instr_addr not word aligned");
        end

endmodule

bind rv_pipeline rv_pipeline_props props_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .instr_addr          (instr_addr),
    .data_addr           (data_addr),
    .data_write_data     (data_write_data),
    .data_read_request   (data_read_request),
    .data_write_request  (data_write_request),
    .data_request_finish (data_request_finish)
);

`default_nettype wire

// ==== verification/rv_pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_pipeline_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int PROG_WORDS  = 34;
    // 40 cycles per instruction and four times that for the slowest bus
    localparam int WATCHDOG_NS = PROG_WORDS * 40 * 4 * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_addr, instr;
    logic [31:0] data_addr, data_write_data, data_read_data;
    logic        data_read_request, data_write_request, data_request_finish;

    logic [31:0] rom [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          emit_idx;
    int          store_idx;
    int          n_stores;
    logic [31:0] lfsr;
    logic        pending;
    logic [1:0]  wait_left;

    rv_pipeline dut_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .instr_addr          (instr_addr),
        .instr               (instr),
        .data_addr           (data_addr),
        .data_write_data     (data_write_data),
        .data_read_request   (data_read_request),
        .data_write_request  (data_write_request),
        .data_read_data      (data_read_data),
        .data_request_finish (data_request_finish)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OP_RTYPE};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, `F3_SW, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `OP_LUI};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h6D2B_79F5;
    endfunction

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_delay(output logic [1:0] delay);
        for (int b = 0; b < 2; b++) begin
            delay[b] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic emit(input logic [31:0] word);
        rom[emit_idx] = word;
        emit_idx++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] value);
        exp_addr.push_back(addr);
        exp_data.push_back(value);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want) else begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, want);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_store();
        if (store_idx >= n_stores) begin
            $display("Store to %h at %0d ns came after the last expected store",
                     data_addr, $time);
            $display("Checks failed");
            $fatal(1);
        end else begin
            compare_value("data_addr", data_addr, exp_addr[store_idx]);
            compare_value("data_write_data", data_write_data, exp_data[store_idx]);
            store_idx++;
        end
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 64; i++) begin
            rom[i]  = `INST_NOP;
            dmem[i] = fill_word(32'(i) << 2);
        end
    endtask

    task automatic build_program();
        logic [31:0] v1, v2, v3, v4, v5, v6, v7, v8, v9, v11, v13;
        v1  = 32'h0000_0123;
        v2  = 32'h1234_5000;
        v3  = v1 + v2;
        v4  = v3 - v1;
        v5  = v4 & v3;
        v6  = v5 | v1;
        v7  = v6 ^ v2;
        v9  = 32'hFFFF_FFFB;
        v8  = ($signed(v9) < $signed(v7)) ? 32'd1 : 32'd0;
        v11 = fill_word(32'h20) + v1;
        v13 = fill_word(32'h24);
        emit_idx = 0;
        // dependent ALU chain
        emit(i_type(12'h123, 5'd0, `F3_ADD_SUB, 5'd1, `OP_ITYPE));
        emit(u_type(20'h12345, 5'd2));
        emit(r_type(`F7_BASE, 5'd2, 5'd1, `F3_ADD_SUB, 5'd3));
        emit(r_type(`F7_SUB, 5'd1, 5'd3, `F3_ADD_SUB, 5'd4));
        emit(r_type(`F7_BASE, 5'd3, 5'd4, `F3_AND, 5'd5));
        emit(r_type(`F7_BASE, 5'd1, 5'd5, `F3_OR, 5'd6));
        emit(r_type(`F7_BASE, 5'd2, 5'd6, `F3_XOR, 5'd7));
        emit(i_type(12'hFFB, 5'd0, `F3_ADD_SUB, 5'd9, `OP_ITYPE));
        emit(r_type(`F7_BASE, 5'd7, 5'd9, `F3_SLT, 5'd8));
        emit(s_type(12'h040, 5'd3, 5'd0));
        emit(s_type(12'h044, 5'd4, 5'd0));
        emit(s_type(12'h048, 5'd5, 5'd0));
        emit(s_type(12'h04C, 5'd6, 5'd0));
        emit(s_type(12'h050, 5'd7, 5'd0));
        emit(s_type(12'h054, 5'd8, 5'd0));
        // load-use
        emit(i_type(12'h020, 5'd0, `F3_LW, 5'd10, `OP_LOAD));
        emit(r_type(`F7_BASE, 5'd1, 5'd10, `F3_ADD_SUB, 5'd11));
        emit(s_type(12'h058, 5'd11, 5'd0));
        // taken BEQ skips two stores and a BNE falls through
        emit(b_type(13'd12, 5'd1, 5'd1, `F3_BEQ));
        emit(s_type(12'h05C, 5'd1, 5'd0));
        emit(s_type(12'h05C, 5'd2, 5'd0));
        emit(b_type(13'd8, 5'd3, 5'd3, `F3_BNE));
        emit(s_type(12'h05C, 5'd9, 5'd0));
        // branches waiting on an ALU result and on a load
        emit(i_type(12'h000, 5'd1, `F3_ADD_SUB, 5'd12, `OP_ITYPE));
        emit(b_type(13'd8, 5'd1, 5'd12, `F3_BEQ));
        emit(s_type(12'h060, 5'd0, 5'd0));
        emit(i_type(12'h024, 5'd0, `F3_LW, 5'd13, `OP_LOAD));
        emit(b_type(13'd8, 5'd0, 5'd13, `F3_BNE));
        emit(s_type(12'h060, 5'd0, 5'd0));
        emit(s_type(12'h060, 5'd13, 5'd0));
        // JAL at 0x78 links 0x7C
        emit(j_type(21'd8, 5'd14));
        emit(s_type(12'h064, 5'd0, 5'd0));
        emit(s_type(12'h064, 5'd14, 5'd0));
        emit(j_type(21'd0, 5'd0));
        expect_store(32'h40, v3);
        expect_store(32'h44, v4);
        expect_store(32'h48, v5);
        expect_store(32'h4C, v6);
        expect_store(32'h50, v7);
        expect_store(32'h54, v8);
        expect_store(32'h58, v11);
        expect_store(32'h5C, v9);
        expect_store(32'h60, v13);
        expect_store(32'h64, 32'd120 + 32'd4);
        n_stores = exp_addr.size();
    endtask

    // memory answers after 0 to 3 cycles
    task automatic drive_inputs();
        if (data_request_finish) begin
            pending = 1'b0;
        end
        data_request_finish = 1'b0;
        if (!pending && (data_read_request || data_write_request)) begin
            pending = 1'b1;
            draw_delay(wait_left);
        end
        if (pending) begin
            if (wait_left == 2'd0) begin
                data_request_finish = 1'b1;
                if (data_read_request) begin
                    data_read_data = dmem[data_addr[7:2]];
                end else begin
                    check_store();
                    dmem[data_addr[7:2]] = data_write_data;
                end
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
        // ROM follows instr_addr
        instr = rom[instr_addr[7:2]];
    endtask

    always @(posedge clk) begin
        #2;
        drive_inputs();
    end

    always @(negedge clk) begin
        if (dut_i.props_i.any_failure) begin
            $display("A bus or fetch property of the DUT failed at %0d ns", $time);
            $display("Checks failed");
            $fatal(1);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns: the program never reached its final store",
                 WATCHDOG_NS);
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        clk                 = 1'b0;
        rst_n               = 1'b0;
        instr               = `INST_NOP;
        data_read_data      = '0;
        data_request_finish = 1'b0;
        lfsr                = 32'd81569;
        pending             = 1'b0;
        wait_left           = 2'd0;
        store_idx           = 0;
        clear_memories();
        build_program();
        repeat (3) @(posedge clk);
        #2;
        // reset state before the first fetch moves on
        compare_value("instr_addr", instr_addr, `RESET_PC);
        compare_value("data_read_request", {31'b0, data_read_request}, 32'd0);
        compare_value("data_write_request", {31'b0, data_write_request}, 32'd0);
        rst_n = 1'b1;
        wait (store_idx == n_stores);
        @(posedge clk);
        if (!dut_i.props_i.any_failure) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
